//--- Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module memTesterTb -f project.f -o memTesterSim
	./obj_dir/memTesterSim | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- project.f
verilog/memTestPkg.sv
verilog/memCmdIf.sv
verilog/apbRegs.sv
verilog/testSequencer.sv
verilog/sramController.sv
verilog/readChecker.sv
verilog/memTester.sv
testbench/sramModel.sv
testbench/memTesterTb.sv

//--- testbench/memTesterTb.sv
module memTesterTb;
    timeunit 1ns;
    timeprecision 1ps;
    import memTestPkg::*;

    localparam int numFixedRows = 9;
    localparam int numRows = 14;
    localparam int apbLimit = 8;
    localparam int doneLimit = 5000;

    typedef struct packed {
        logic [addrWidth:0] count;
        logic pattern;
        logic [addrWidth-1:0] faultAddr;
        logic [dataWidth-1:0] faultMask;
    } testRow;

    logic clk;
    logic rstN;
    logic [apbAddrWidth-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic irq;
    logic sramCe;
    logic sramWe;
    logic [addrWidth-1:0] sramAddr;
    logic [dataWidth-1:0] sramWdata;
    logic [dataWidth-1:0] sramRdata;

    testRow rows [numRows];
    logic [31:0] lfsr;

    memTester memTester_i (.*);

    sramModel sram_i (.clk(clk), .ce(sramCe), .we(sramWe), .addr(sramAddr),
                      .wdata(sramWdata), .rdata(sramRdata));

    always #50 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
        end
    endtask

    // one APB transfer, the response is sampled mid-cycle in the access phase
    task automatic apbTransfer(input logic write, input logic [apbAddrWidth-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        int cycles;
        cycles = 0;
        @(posedge clk);
        paddr <= addr;
        pwrite <= write;
        pwdata <= wdata;
        psel <= 1'b1;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            if (cycles == apbLimit) begin
                abortRun("APB access phase never saw pready");
            end
            cycles++;
            @(negedge clk);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    task automatic waitForIrq();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!irq) begin
            if (cycles == doneLimit) begin
                abortRun("test did not finish, irq never rose");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic runRow(input string name, input testRow row);
        logic [dataWidth-1:0] word;
        logic exposed;
        logic [31:0] value;
        logic err;
        // a stuck-at-one bit only shows where the written word holds a zero
        word = row.pattern ? ~dataWidth'(row.faultAddr) : dataWidth'(row.faultAddr);
        exposed = {1'b0, row.faultAddr} < row.count && (row.faultMask & ~word) != '0;
        sram_i.faultAddr <= row.faultAddr;
        sram_i.faultMask <= row.faultMask;
        apbTransfer(1'b1, regCount, 32'(row.count), value, err);
        checkValue({name, " count slverr"}, 32'd0, 32'(err));
        apbTransfer(1'b1, regCtrl, {30'd0, row.pattern, 1'b1}, value, err);
        waitForIrq();
        apbTransfer(1'b0, regStatus, '0, value, err);
        checkValue({name, " status"}, 32'h2, value);
        apbTransfer(1'b0, regErrCount, '0, value, err);
        checkValue({name, " errCount"}, exposed ? 32'd1 : 32'd0, value);
        apbTransfer(1'b0, regErrAddr, '0, value, err);
        checkValue({name, " errAddr"},
                   exposed ? 32'(row.faultAddr) : 32'({addrWidth{1'b1}}), value);
    endtask

    initial begin
        logic [31:0] value;
        logic [31:0] bits;
        logic err;
        clk = 1'b0;
        rstN <= 1'b0;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= '0;
        pwdata <= '0;
        sram_i.faultAddr <= '0;
        sram_i.faultMask <= '0;
        lfsr = 32'hb34d_3a9a;

        // count, pattern, fault address, fault mask
        rows[0] = '{11'd1, 1'b0, 10'd0, 16'h0000};
        rows[1] = '{11'd17, 1'b1, 10'd0, 16'h0000};
        rows[2] = '{11'd1024, 1'b0, 10'd0, 16'h0000};
        rows[3] = '{11'd1024, 1'b1, 10'd0, 16'h0000};
        rows[4] = '{11'd100, 1'b0, 10'd37, 16'h0040};
        rows[5] = '{11'd100, 1'b0, 10'd37, 16'h0001};
        rows[6] = '{11'd64, 1'b1, 10'd5, 16'h0001};
        rows[7] = '{11'd50, 1'b0, 10'd60, 16'h8000};
        rows[8] = '{11'd33, 1'b1, 10'd32, 16'h0020};
        for (int i = numFixedRows; i < numRows; i++) begin
            takeBits(addrWidth, bits);
            rows[i].faultAddr = bits[addrWidth-1:0];
            takeBits(4, bits);
            rows[i].faultMask = 16'(1) << bits[3:0];
            rows[i].count = 11'd512;
            rows[i].pattern = i[0];
        end

        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        apbTransfer(1'b0, regStatus, '0, value, err);
        checkValue("reset status", 32'h0, value);
        apbTransfer(1'b1, regCount, 32'd0, value, err);
        apbTransfer(1'b0, regCount, '0, value, err);
        checkValue("count zero clamp", 32'd1024, value);
        apbTransfer(1'b1, regCount, 32'd2000, value, err);
        apbTransfer(1'b0, regCount, '0, value, err);
        checkValue("count high clamp", 32'd1024, value);
        apbTransfer(1'b1, regCount, 32'd300, value, err);
        apbTransfer(1'b0, regCount, '0, value, err);
        checkValue("count readback", 32'd300, value);
        apbTransfer(1'b0, 8'h14, '0, value, err);
        checkValue("unknown offset slverr", 32'd1, 32'(err));
        apbTransfer(1'b1, regStatus, 32'd1, value, err);
        checkValue("read-only write slverr", 32'd1, 32'(err));

        for (int i = 0; i < numRows; i++) begin
            runRow($sformatf("row %0d", i), rows[i]);
        end

        // second start and new count while busy, the running test keeps its setup
        sram_i.faultAddr <= 10'd200;
        sram_i.faultMask <= 16'h0001;
        apbTransfer(1'b1, regCount, 32'd1024, value, err);
        apbTransfer(1'b1, regCtrl, 32'h1, value, err);
        apbTransfer(1'b0, regStatus, '0, value, err);
        checkValue("busy status", 32'h1, value);
        apbTransfer(1'b1, regCount, 32'd10, value, err);
        apbTransfer(1'b1, regCtrl, 32'h3, value, err);
        waitForIrq();
        apbTransfer(1'b0, regErrCount, '0, value, err);
        checkValue("busy restart errCount", 32'd1, value);
        apbTransfer(1'b0, regErrAddr, '0, value, err);
        checkValue("busy restart errAddr", 32'd200, value);
        apbTransfer(1'b0, regCtrl, '0, value, err);
        checkValue("busy restart ctrl", 32'h0, value);
        apbTransfer(1'b0, regCount, '0, value, err);
        checkValue("busy restart count", 32'd1024, value);

        $display("All tests passed");
        $finish;
    end

endmodule

//--- testbench/sramModel.sv
module sramModel (
    input  logic clk,
    input  logic ce,
    input  logic we,
    input  logic [memTestPkg::addrWidth-1:0] addr,
    input  logic [memTestPkg::dataWidth-1:0] wdata,
    output logic [memTestPkg::dataWidth-1:0] rdata
);
    timeunit 1ns;
    timeprecision 1ps;
    import memTestPkg::*;

    logic [dataWidth-1:0] mem [memWords];
    logic [dataWidth-1:0] readStage;

    // one address reads back with the masked bits stuck at one, a zero mask means no fault
    logic [addrWidth-1:0] faultAddr;
    logic [dataWidth-1:0] faultMask;

    // two register stages give the fixed read latency
    always @(posedge clk) begin
        if (ce && we) begin
            mem[addr] <= wdata;
        end
        if (ce && !we) begin
            readStage <= (addr == faultAddr) ? (mem[addr] | faultMask) : mem[addr];
        end
        rdata <= readStage;
    end

endmodule

//--- verilog/apbRegs.sv
module apbRegs (
    input  logic clk,
    input  logic rstN,
    input  logic [memTestPkg::apbAddrWidth-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [31:0] pwdata,
    input  logic done,
    input  logic [15:0] errCount,
    input  logic [memTestPkg::addrWidth-1:0] errAddr,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic start,
    output logic [memTestPkg::addrWidth:0] count,
    output memTestPkg::patternMode pattern,
    output logic busy,
    output logic irq
);
    import memTestPkg::*;

    logic access;
    logic writeEn;
    logic knownReg;
    logic readOnlyReg;
    logic doneFlag;

    assign access = psel && penable;
    assign writeEn = access && pwrite;

    // no wait states, every access phase completes at once
    assign pready = access;
    assign pslverr = access && (!knownReg || (pwrite && readOnlyReg));
    assign irq = doneFlag;

    always_comb begin
        knownReg = 1'b1;
        readOnlyReg = 1'b0;
        prdata = '0;
        case (paddr)
            regCtrl: prdata = {30'd0, pattern, 1'b0};
            regCount: prdata = 32'(count);
            regStatus: begin
                prdata = {30'd0, doneFlag, busy};
                readOnlyReg = 1'b1;
            end
            regErrCount: begin
                prdata = 32'(errCount);
                readOnlyReg = 1'b1;
            end
            regErrAddr: begin
                prdata = 32'(errAddr);
                readOnlyReg = 1'b1;
            end
            default: knownReg = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            start <= 1'b0;
            busy <= 1'b0;
            doneFlag <= 1'b0;
            count <= (addrWidth+1)'(memWords);
            pattern <= patAddr;
        end else begin
            start <= 1'b0;
            if (done) begin
                busy <= 1'b0;
                doneFlag <= 1'b1;
            end
            // configuration is frozen while a test runs, so a late start is dropped too
            if (writeEn && !busy) begin
                if (paddr == regCtrl) begin
                    pattern <= patternMode'(pwdata[1]);
                    if (pwdata[0]) begin
                        start <= 1'b1;
                        busy <= 1'b1;
                        doneFlag <= 1'b0;
                    end
                end
                if (paddr == regCount) begin
                    count <= (pwdata == 32'd0 || pwdata > memWords) ?
                             (addrWidth+1)'(memWords) : pwdata[addrWidth:0];
                end
            end
        end
    end

    apbEnableNeedsSel: assert property (@(posedge clk) disable iff (!rstN)
        penable |-> psel)
        else $error("penable high without psel");

endmodule

//--- verilog/memCmdIf.sv
interface memCmdIf;
    import memTestPkg::*;

    logic ready;
    logic trigger;
    logic [addrWidth-1:0] addr;
    logic write;
    logic [dataWidth-1:0] writeData;
    logic [dataWidth-1:0] readData;
    logic readDataValid;

    // a command is taken on every cycle with trigger and ready both high
    modport seq (
        output trigger, addr, write, writeData,
        input ready
    );

    modport ctrl (
        input trigger, addr, write, writeData,
        output ready, readData, readDataValid
    );

    modport chk (
        input readData, readDataValid
    );

endinterface

//--- verilog/memTestPkg.sv
package memTestPkg;

    localparam int addrWidth = 10;
    localparam int dataWidth = 16;
    localparam int apbAddrWidth = 8;

    // number of words covered by a full-range test
    localparam int memWords = 1 << addrWidth;

    localparam logic [apbAddrWidth-1:0] regCtrl = 8'h00;
    localparam logic [apbAddrWidth-1:0] regCount = 8'h04;
    localparam logic [apbAddrWidth-1:0] regStatus = 8'h08;
    localparam logic [apbAddrWidth-1:0] regErrCount = 8'h0C;
    localparam logic [apbAddrWidth-1:0] regErrAddr = 8'h10;

    // the controller drops ready for one cycle after this many accepted commands
    localparam int refreshInterval = 16;
    localparam int refreshCountWidth = $clog2(refreshInterval);

    localparam int readLatency = 2;

    typedef enum logic {
        patAddr = 1'b0,
        patInvAddr = 1'b1
    } patternMode;

    // expected memory word for an address under the selected pattern
    function automatic logic [dataWidth-1:0] patternData(input logic [addrWidth-1:0] addr,
                                                         input patternMode mode);
        logic [dataWidth-1:0] base;
        base = dataWidth'(addr);
        return (mode == patInvAddr) ? ~base : base;
    endfunction

endpackage

//--- verilog/memTester.sv
module memTester (
    input  logic clk,
    input  logic rstN,
    input  logic [memTestPkg::apbAddrWidth-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic irq,
    output logic sramCe,
    output logic sramWe,
    output logic [memTestPkg::addrWidth-1:0] sramAddr,
    output logic [memTestPkg::dataWidth-1:0] sramWdata,
    input  logic [memTestPkg::dataWidth-1:0] sramRdata
);
    import memTestPkg::*;

    logic start;
    logic [addrWidth:0] count;
    patternMode pattern;
    logic done;
    logic [15:0] errCount;
    logic [addrWidth-1:0] errAddr;

    memCmdIf cmdBus ();

    apbRegs regs_i (
        .clk(clk),
        .rstN(rstN),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .done(done),
        .errCount(errCount),
        .errAddr(errAddr),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .start(start),
        .count(count),
        .pattern(pattern),
        .busy(),
        .irq(irq)
    );

    testSequencer seq_i (
        .clk(clk),
        .rstN(rstN),
        .start(start),
        .count(count),
        .pattern(pattern),
        .cmd(cmdBus.seq)
    );

    sramController ctrl_i (
        .clk(clk),
        .rstN(rstN),
        .sramRdata(sramRdata),
        .cmd(cmdBus.ctrl),
        .sramCe(sramCe),
        .sramWe(sramWe),
        .sramAddr(sramAddr),
        .sramWdata(sramWdata)
    );

    readChecker chk_i (
        .clk(clk),
        .rstN(rstN),
        .start(start),
        .count(count),
        .pattern(pattern),
        .cmd(cmdBus.chk),
        .done(done),
        .errCount(errCount),
        .errAddr(errAddr)
    );

endmodule

//--- verilog/readChecker.sv
module readChecker (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic [memTestPkg::addrWidth:0] count,
    input  memTestPkg::patternMode pattern,
    memCmdIf.chk cmd,
    output logic done,
    output logic [15:0] errCount,
    output logic [memTestPkg::addrWidth-1:0] errAddr
);
    import memTestPkg::*;

    logic [addrWidth-1:0] expAddr;
    logic [addrWidth-1:0] lastAddr;
    logic mismatch;

    assign lastAddr = addrWidth'(count - 1'b1);
    assign mismatch = cmd.readData != patternData(expAddr, pattern);

    // reads come back in order, so the expected address just counts up
    assign done = cmd.readDataValid && (expAddr == lastAddr);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            expAddr <= '0;
            errCount <= '0;
            errAddr <= '1;
        end else if (start) begin
            expAddr <= '0;
            errCount <= '0;
            errAddr <= '1;
        end else if (cmd.readDataValid) begin
            expAddr <= expAddr + 1'b1;
            if (mismatch) begin
                errCount <= errCount + 1'b1;
                // only the first failing address is kept
                if (errCount == '0) begin
                    errAddr <= expAddr;
                end
            end
        end
    end

endmodule

//--- verilog/sramController.sv
module sramController (
    input  logic clk,
    input  logic rstN,
    input  logic [memTestPkg::dataWidth-1:0] sramRdata,
    memCmdIf.ctrl cmd,
    output logic sramCe,
    output logic sramWe,
    output logic [memTestPkg::addrWidth-1:0] sramAddr,
    output logic [memTestPkg::dataWidth-1:0] sramWdata
);
    import memTestPkg::*;

    logic accepted;
    logic [refreshCountWidth-1:0] acceptCount;
    logic [readLatency:0] readTag;

    assign accepted = cmd.trigger && cmd.ready;

    // the SRAM output is already aligned by the tag pipe
    assign cmd.readData = sramRdata;
    assign cmd.readDataValid = readTag[readLatency];

    // refresh-like stall, one dead cycle per block of accepted commands
    always_ff @(posedge clk) begin
        if (!rstN) begin
            cmd.ready <= 1'b0;
            acceptCount <= '0;
        end else if (accepted) begin
            if (acceptCount == refreshCountWidth'(refreshInterval - 1)) begin
                acceptCount <= '0;
                cmd.ready <= 1'b0;
            end else begin
                acceptCount <= acceptCount + 1'b1;
                cmd.ready <= 1'b1;
            end
        end else begin
            cmd.ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sramCe <= 1'b0;
            sramWe <= 1'b0;
            readTag <= '0;
        end else begin
            sramCe <= accepted;
            sramWe <= accepted && cmd.write;
            readTag <= {readTag[readLatency-1:0], accepted && !cmd.write};
        end
    end

    always_ff @(posedge clk) begin
        if (accepted) begin
            sramAddr <= cmd.addr;
            sramWdata <= cmd.writeData;
        end
    end

    readValidFollowsRead: assert property (@(posedge clk) disable iff (!rstN)
        cmd.readDataValid |-> $past(cmd.trigger && cmd.ready && !cmd.write, readLatency + 1))
        else $error("read data valid without a matching read command");

endmodule

//--- verilog/testSequencer.sv
module testSequencer (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic [memTestPkg::addrWidth:0] count,
    input  memTestPkg::patternMode pattern,
    memCmdIf.seq cmd
);
    import memTestPkg::*;

    typedef enum logic [1:0] {
        idle,
        writePass,
        readPass
    } seqState;

    seqState state;
    logic [addrWidth-1:0] lastAddr;
    logic [addrWidth-1:0] nextAddr;
    logic accepted;

    // count is at least one, the register block clamps zero to a full range
    assign lastAddr = addrWidth'(count - 1'b1);
    assign nextAddr = cmd.addr + 1'b1;
    assign accepted = cmd.trigger && cmd.ready;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= idle;
            cmd.trigger <= 1'b0;
            cmd.addr <= '0;
            cmd.write <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= writePass;
                        cmd.trigger <= 1'b1;
                        cmd.addr <= '0;
                        cmd.write <= 1'b1;
                        cmd.writeData <= patternData('0, pattern);
                    end
                end

                writePass: begin
                    if (accepted) begin
                        if (cmd.addr == lastAddr) begin
                            // trigger stays high, the read pass follows without a gap
                            state <= readPass;
                            cmd.addr <= '0;
                            cmd.write <= 1'b0;
                        end else begin
                            cmd.addr <= nextAddr;
                            cmd.writeData <= patternData(nextAddr, pattern);
                        end
                    end
                end

                readPass: begin
                    if (accepted) begin
                        if (cmd.addr == lastAddr) begin
                            state <= idle;
                            cmd.trigger <= 1'b0;
                        end else begin
                            cmd.addr <= nextAddr;
                        end
                    end
                end

                default: begin
                    state <= idle;
                    cmd.trigger <= 1'b0;
                end
            endcase
        end
    end

    // while the controller stalls, the pending command must not move
    cmdHoldWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        cmd.trigger && !cmd.ready |=>
            cmd.trigger && $stable(cmd.addr) && $stable(cmd.write) && $stable(cmd.writeData))
        else $error("command changed while stalled");

endmodule
